// ==== filelist.f ====
lenet_pkg.sv
lenet_cfg_if.sv
lenet_approx_mul.sv
lenet_weight_regs.sv
lenet_mac_pipe.sv
lenet_conv_unit.sv
tb_lenet_conv_unit.sv

// ==== Bender.yml ====
package:
  name: lenet_conv_unit

sources:
  - lenet_pkg.sv
  - lenet_cfg_if.sv
  - lenet_approx_mul.sv
  - lenet_weight_regs.sv
  - lenet_mac_pipe.sv
  - lenet_conv_unit.sv
  - target: test
    files:
      - tb_lenet_conv_unit.sv

// ==== tb_lenet_conv_unit.sv ====
`default_nettype none

module tb_lenet_conv_unit;

    localparam int clk_period   = 40;
    localparam int reset_cycles = 10;
    // watchdog limit is twice the rough cycle cost of all tests
    localparam int test_cycles  = 80 + 600 + 120 + 70 + 250 + 80;
    localparam int timeout_cycles = 2 * (reset_cycles + test_cycles);

    logic                           clk;
    logic                           rst_n;
    logic                           cfg_valid;
    lenet_pkg::cfg_op_e             cfg_op;
    logic [lenet_pkg::tap_w-1:0]    cfg_addr;
    logic [lenet_pkg::cfg_w-1:0]    cfg_data;
    logic                           act_valid;
    logic                           act_ready;
    logic [lenet_pkg::act_w-1:0]    act_data;
    logic                           res_valid;
    logic                           res_ready;
    logic [lenet_pkg::act_w-1:0]    res_data;

    int w_mdl [lenet_pkg::n_taps];   // mirror of the kernel registers
    int bias_mdl;
    int shift_mdl;
    int kernel [lenet_pkg::n_taps];  // next kernel to load
    int win [lenet_pkg::n_taps];     // next window of activations
    int exp_q [$];
    int ninth_q [$];                 // cycle of each ninth accepted tap
    bit ready_pat [$];
    int errors, checks, tests_run, cyc, taps_seen, stall_cycles, wd_cycles;
    int seed_val;
    bit check_latency, prev_wait;
    logic [lenet_pkg::act_w-1:0] prev_data;

    lenet_conv_unit dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg_valid (cfg_valid),
        .cfg_op    (cfg_op),
        .cfg_addr  (cfg_addr),
        .cfg_data  (cfg_data),
        .act_valid (act_valid),
        .act_ready (act_ready),
        .act_data  (act_data),
        .res_valid (res_valid),
        .res_ready (res_ready),
        .res_data  (res_data)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    function automatic int at_weight(input bit b, input int k);
        return b ? (1 << k) : 0;
    endfunction

    // rows 6 and 7 kept whole and the low rows reduced to sparse correction bits
    function automatic int approx_prod(input int w, input int a);
        logic [7:0] r [8];
        int p;
        for (int i = 0; i < 8; i++) r[i] = w[i] ? a[7:0] : 8'd0;
        p = (int'(r[6]) << 6) + (int'(r[7]) << 7);
        p += at_weight(r[0][3] ^ r[1][2], 4) + at_weight(r[0][6] ^ r[1][5], 7);
        p += at_weight(r[0][7] | r[1][6], 8) + at_weight(r[2][7] | r[3][6], 9);
        p += at_weight(r[3][7], 10) + at_weight(r[4][7] ^ r[5][6], 11);
        p += at_weight(r[4][7] & r[5][6], 12) + at_weight(r[0][7] & r[1][6], 7);
        p += at_weight(r[2][5] & r[3][4], 8) + at_weight(r[4][4] | r[5][3], 9);
        p += at_weight(r[4][5] & r[5][4], 10) + at_weight(r[5][7], 12);
        p += at_weight(r[2][6] | r[3][5], 8) + at_weight(r[4][5] ^ r[5][4], 9);
        p += at_weight(r[4][6] & r[5][5], 10) + at_weight(r[4][3] | r[5][2], 8);
        p += at_weight(r[4][6] | r[5][5], 10);
        return p & 16'hffff;
    endfunction

    // bias, relu, logical shift, saturate
    function automatic int post_process(input int sum);
        int v;
        v = sum + bias_mdl;
        if (v < 0) v = 0;
        v = v >> shift_mdl;
        return (v > 255) ? 255 : v;
    endfunction

    function automatic int model_window();
        int sum;
        sum = 0;
        for (int i = 0; i < lenet_pkg::n_taps; i++) sum += approx_prod(w_mdl[i], win[i]);
        return post_process(sum);
    endfunction

    task automatic check_value(input string name, input int got, input int exp);
        checks++;
        assert (got == exp) else begin
            $display("error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_true(input bit cond, input string what);
        checks++;
        assert (cond) else begin
            $display("at %0t: %s", $time, what);
            errors++;
        end
    endtask

    task automatic write_cfg(input lenet_pkg::cfg_op_e op, input int addr, input int data);
        logic signed [15:0] b16;
        cfg_valid = 1'b1;
        cfg_op    = op;
        cfg_addr  = lenet_pkg::tap_w'(addr);
        cfg_data  = lenet_pkg::cfg_w'(data);
        @(negedge clk);
        cfg_valid = 1'b0;
        cfg_op    = lenet_pkg::cfg_nop;
        b16       = data[15:0];
        case (op)
            lenet_pkg::cfg_weight: if (addr < lenet_pkg::n_taps) w_mdl[addr] = data & 255;
            lenet_pkg::cfg_bias:   bias_mdl = b16;
            lenet_pkg::cfg_shift:  shift_mdl = data & 15;
            default: ;
        endcase
    endtask

    task automatic load_kernel(input int bias, input int shift);
        for (int i = 0; i < lenet_pkg::n_taps; i++) write_cfg(lenet_pkg::cfg_weight, i, kernel[i]);
        write_cfg(lenet_pkg::cfg_bias, 0, bias);
        write_cfg(lenet_pkg::cfg_shift, 0, shift);
    endtask

    // starts and ends on a falling edge with act_valid left high
    task automatic send_window();
        for (int i = 0; i < lenet_pkg::n_taps; i++) begin
            act_valid = 1'b1;
            act_data  = lenet_pkg::act_w'(win[i]);
            @(posedge clk);
            while (!act_ready) @(posedge clk);
            @(negedge clk);
        end
    endtask

    task automatic wait_drain();
        act_valid = 1'b0;
        while (exp_q.size() != 0) @(negedge clk);
        @(negedge clk);
    endtask

    task automatic run_window();
        exp_q.push_back(model_window());
        send_window();
        wait_drain();
    endtask

    task automatic report_test(input string name, input int err_before);
        tests_run++;
        $display("test %s done, %0d errors", name, errors - err_before);
    endtask

    task automatic test_exact();
        int e0, sum;
        e0 = errors;
        for (int i = 0; i < lenet_pkg::n_taps; i++) kernel[i] = (i % 2) ? 128 : 64;
        load_kernel(0, 0);
        for (int n = 0; n < 3; n++) begin
            sum = 0;
            for (int i = 0; i < lenet_pkg::n_taps; i++) begin
                win[i] = (n == 2) ? $urandom_range(0, 255) : ((i == n || i == n + 1) ? 1 : 0);
                sum += kernel[i] * win[i];
            end
            exp_q.push_back((sum > 255) ? 255 : sum);  // exact product for these weights
            send_window();
            wait_drain();
        end
        report_test("exact", e0);
    endtask

    task automatic test_approx();
        int e0, diffs;
        int exact_sum;
        e0 = errors;
        diffs = 0;
        for (int n = 0; n < 20; n++) begin
            exact_sum = 0;
            for (int i = 0; i < lenet_pkg::n_taps; i++) begin
                kernel[i] = $urandom_range(0, 255);
                win[i]    = $urandom_range(0, 255);
                exact_sum += kernel[i] * win[i];
            end
            load_kernel(int'($urandom_range(0, 400)) - 200, $urandom_range(10, 12));
            if (model_window() != post_process(exact_sum)) diffs++;  // visible at the output
            run_window();
        end
        check_true(diffs > 0, "approximate results never differed from exact ones");
        report_test("approx", e0);
    endtask

    task automatic test_post();
        int e0;
        e0 = errors;
        for (int i = 0; i < lenet_pkg::n_taps; i++) begin
            kernel[i] = 128;
            win[i]    = 10;
        end
        load_kernel(-20000, 0);
        run_window();
        write_cfg(lenet_pkg::cfg_bias, 0, 100);
        foreach (win[i]) win[i] = 1;
        for (int s = 0; s < 3; s++) begin
            write_cfg(lenet_pkg::cfg_shift, 0, (s == 0) ? 0 : ((s == 1) ? 4 : 15));
            run_window();
        end
        write_cfg(lenet_pkg::cfg_bias, 0, -1153);  // one below the sum
        write_cfg(lenet_pkg::cfg_shift, 0, 0);
        run_window();
        foreach (win[i]) win[i] = 255;
        write_cfg(lenet_pkg::cfg_bias, 0, 0);
        run_window();
        report_test("post", e0);
    endtask

    task automatic test_back_to_back();
        int e0;
        e0 = errors;
        for (int i = 0; i < lenet_pkg::n_taps; i++) kernel[i] = $urandom_range(0, 255);
        load_kernel(0, 11);
        check_latency = 1'b1;
        for (int n = 0; n < 3; n++) begin
            foreach (win[i]) win[i] = $urandom_range(0, 255);
            exp_q.push_back(model_window());
            send_window();
        end
        wait_drain();
        check_latency = 1'b0;
        report_test("back_to_back", e0);
    endtask

    task automatic test_backpressure();
        int e0, stalls0;
        e0 = errors;
        stalls0 = stall_cycles;
        for (int i = 0; i < lenet_pkg::n_taps; i++) kernel[i] = $urandom_range(0, 255);
        load_kernel($urandom_range(0, 300), 11);
        for (int s = 0; s < 8; s++) begin
            repeat ($urandom_range(12, 20)) ready_pat.push_back(1'b0);
            repeat ($urandom_range(1, 3)) ready_pat.push_back(1'b1);
        end
        for (int n = 0; n < 6; n++) begin
            foreach (win[i]) win[i] = $urandom_range(0, 255);
            exp_q.push_back(model_window());
            send_window();
        end
        wait_drain();
        check_true(stall_cycles > stalls0, "back-pressure never stalled the activation stream");
        report_test("backpressure", e0);
    endtask

    task automatic test_reconfig();
        int e0;
        e0 = errors;
        foreach (kernel[i]) kernel[i] = i + 1;
        load_kernel(0, 0);
        foreach (win[i]) win[i] = 3;
        run_window();
        foreach (kernel[i]) kernel[i] = 200 - 7 * i;
        load_kernel(-50, 2);
        write_cfg(lenet_pkg::cfg_weight, 12, 8'hff);  // beyond the kernel
        foreach (win[i]) win[i] = 40 + i;
        run_window();
        report_test("reconfig", e0);
    endtask

    // response monitor sampled on the rising edge
    always @(posedge clk) begin
        if (rst_n) begin
            if (act_valid && act_ready) begin
                taps_seen++;
                if (taps_seen == lenet_pkg::n_taps) begin
                    taps_seen = 0;
                    ninth_q.push_back(cyc);
                end
            end
            if (!act_ready) begin
                stall_cycles++;
                check_true(res_valid && !res_ready, "act_ready low without a blocked result");
            end
            if (prev_wait) begin
                check_true(res_valid, "res_valid dropped before the transfer");
                check_value("res_data", res_data, prev_data);
            end
            if (res_valid && res_ready) begin
                if (exp_q.size() == 0) check_true(1'b0, "result arrived with none expected");
                else check_value("res_data", res_data, exp_q.pop_front());
                if (ninth_q.size() != 0 && check_latency) begin
                    check_value("res_valid latency", cyc - ninth_q.pop_front(), 2);
                end else if (ninth_q.size() != 0) begin
                    void'(ninth_q.pop_front());
                end
            end
            prev_wait = res_valid && !res_ready;
            prev_data = res_data;
        end
        cyc++;
    end

    initial begin
        forever begin
            @(negedge clk);
            res_ready = (ready_pat.size() != 0) ? ready_pat.pop_front() : 1'b1;
        end
    end

    initial begin
        wd_cycles = 0;
        while (wd_cycles < timeout_cycles) begin
            @(posedge clk);
            wd_cycles++;
        end
        $display("timeout: the run did not complete within %0d cycles", timeout_cycles);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        seed_val = 32'h1ebd_9e2e;
        void'($urandom(seed_val));
        rst_n     = 1'b0;
        cfg_valid = 1'b0;
        cfg_op    = lenet_pkg::cfg_nop;
        cfg_addr  = '0;
        cfg_data  = '0;
        act_valid = 1'b0;
        act_data  = '0;
        res_ready = 1'b1;
        foreach (w_mdl[i]) w_mdl[i] = 0;
        bias_mdl  = 0;
        shift_mdl = 0;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        test_exact();
        test_approx();
        test_post();
        test_back_to_back();
        test_backpressure();
        test_reconfig();
        check_true(exp_q.size() == 0, "expected results left over at the end");
        $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== lenet_conv_unit.sv ====
`default_nettype none

// one convolution tap engine
module lenet_conv_unit (
    input  logic                          clk,
    input  logic                          rst_n,

    input  logic                          cfg_valid,
    input  lenet_pkg::cfg_op_e            cfg_op,
    input  logic [lenet_pkg::tap_w-1:0]   cfg_addr,
    input  logic [lenet_pkg::cfg_w-1:0]   cfg_data,

    input  logic                          act_valid,
    output logic                          act_ready,
    input  logic [lenet_pkg::act_w-1:0]   act_data,

    output logic                          res_valid,
    input  logic                          res_ready,
    output logic [lenet_pkg::act_w-1:0]   res_data
);

    lenet_cfg_if cfg_if_i ();

    lenet_weight_regs regs_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg_valid (cfg_valid),
        .cfg_op    (cfg_op),
        .cfg_addr  (cfg_addr),
        .cfg_data  (cfg_data),
        .cfg       (cfg_if_i.regs)
    );

    lenet_mac_pipe mac_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .act_valid (act_valid),
        .act_ready (act_ready),
        .act_data  (act_data),
        .res_valid (res_valid),
        .res_ready (res_ready),
        .res_data  (res_data),
        .cfg       (cfg_if_i.mac)
    );

endmodule

`default_nettype wire

// ==== lenet_mac_pipe.sv ====
`default_nettype none

// streaming 3x3 MAC with bias, ReLU, shift and saturation
module lenet_mac_pipe (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         act_valid,
    output logic                         act_ready,
    input  logic [lenet_pkg::act_w-1:0]  act_data,
    output logic                         res_valid,
    input  logic                         res_ready,
    output logic [lenet_pkg::act_w-1:0]  res_data,
    lenet_cfg_if.mac                     cfg
);

    logic [lenet_pkg::tap_w-1:0]  tap_cnt;
    logic [lenet_pkg::prod_w-1:0] prod;
    logic                         accept;
    logic                         advance;
    logic                         last_tap;

    // stage 1
    logic                         s1_valid;
    logic                         s1_last;
    logic [lenet_pkg::prod_w-1:0] s1_prod;

    // stage 2
    logic signed [lenet_pkg::acc_w-1:0] acc;
    logic signed [lenet_pkg::acc_w-1:0] acc_next;
    logic signed [lenet_pkg::acc_w-1:0] biased;
    logic        [lenet_pkg::acc_w-1:0] relu;
    logic        [lenet_pkg::acc_w-1:0] shifted;
    logic        [lenet_pkg::act_w-1:0] sat;
    lenet_pkg::out_state_e              out_state;
    logic        [lenet_pkg::act_w-1:0] res_q;

    lenet_approx_mul mul_i (
        .x (cfg.weight_tap),  // weight picks the rows
        .y (act_data),
        .z (prod)
    );

    // stall only when a finished window cannot leave
    assign advance   = !(out_state == lenet_pkg::out_full && !res_ready && s1_valid && s1_last);
    assign act_ready = advance;
    assign accept    = act_valid && act_ready;
    assign last_tap  = (tap_cnt == lenet_pkg::tap_w'(lenet_pkg::n_taps - 1));

    assign cfg.tap  = tap_cnt;
    assign cfg.busy = (tap_cnt != '0) || s1_valid;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tap_cnt  <= '0;
            s1_valid <= 1'b0;
        end else if (advance) begin
            s1_valid <= accept;
            if (accept) begin
                tap_cnt <= last_tap ? '0 : tap_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (advance && accept) begin
            s1_prod <= prod;
            s1_last <= last_tap;
        end
    end

    always_comb begin
        acc_next = acc + $signed({{(lenet_pkg::acc_w - lenet_pkg::prod_w){1'b0}}, s1_prod});
        biased   = acc_next
                 + {{(lenet_pkg::acc_w - lenet_pkg::bias_w){cfg.bias[lenet_pkg::bias_w-1]}},
                    cfg.bias};
        relu     = biased[lenet_pkg::acc_w-1] ? '0 : biased;
        shifted  = relu >> cfg.shift;
        sat      = (|shifted[lenet_pkg::acc_w-1:lenet_pkg::act_w])
                 ? {lenet_pkg::act_w{1'b1}} : shifted[lenet_pkg::act_w-1:0];
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            acc       <= '0;
            out_state <= lenet_pkg::out_empty;
        end else begin
            if (res_valid && res_ready) out_state <= lenet_pkg::out_empty;
            if (advance && s1_valid) begin
                if (s1_last) begin
                    acc       <= '0;
                    out_state <= lenet_pkg::out_full;  // drain and refill on one edge
                end else begin
                    acc <= acc_next;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (advance && s1_valid && s1_last) res_q <= sat;
    end

    assign res_valid = (out_state == lenet_pkg::out_full);
    assign res_data  = res_q;

    a_res_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        res_valid && !res_ready |=> res_valid && $stable(res_data)
    ) else $error("result changed while waiting for res_ready");

    a_tap_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        tap_cnt <= lenet_pkg::tap_w'(lenet_pkg::n_taps - 1)
    ) else $error("tap counter past the last tap");

endmodule

`default_nettype wire

// ==== lenet_weight_regs.sv ====
`default_nettype none

// kernel weights, bias and output shift
module lenet_weight_regs (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          cfg_valid,
    input  lenet_pkg::cfg_op_e            cfg_op,
    input  logic [lenet_pkg::tap_w-1:0]   cfg_addr,
    input  logic [lenet_pkg::cfg_w-1:0]   cfg_data,
    lenet_cfg_if.regs                     cfg
);

    logic        [lenet_pkg::act_w-1:0]   weights [lenet_pkg::n_taps];
    logic signed [lenet_pkg::bias_w-1:0]  bias_q;
    logic        [lenet_pkg::shift_w-1:0] shift_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < lenet_pkg::n_taps; i++) begin
                weights[i] <= '0;
            end
            bias_q  <= '0;
            shift_q <= '0;
        end else if (cfg_valid) begin
            case (cfg_op)
                lenet_pkg::cfg_weight: begin
                    if (cfg_addr < lenet_pkg::tap_w'(lenet_pkg::n_taps)) begin
                        weights[cfg_addr] <= cfg_data[lenet_pkg::act_w-1:0];
                    end  // addresses past the kernel are dropped
                end
                lenet_pkg::cfg_bias:  bias_q  <= cfg_data[lenet_pkg::bias_w-1:0];
                lenet_pkg::cfg_shift: shift_q <= cfg_data[lenet_pkg::shift_w-1:0];
                default: ;
            endcase
        end
    end

    // tap index comes from the pipeline's counter
    assign cfg.weight_tap = (cfg.tap < lenet_pkg::tap_w'(lenet_pkg::n_taps))
                          ? weights[cfg.tap] : '0;
    assign cfg.bias  = bias_q;
    assign cfg.shift = shift_q;

    // reconfiguring mid-window would mix old and new kernels
    a_no_write_while_busy: assert property (
        @(posedge clk) disable iff (!rst_n)
        cfg_valid |-> !cfg.busy
    ) else $error("configuration write while a window is in progress");

endmodule

`default_nettype wire

// ==== lenet_approx_mul.sv ====
`default_nettype none

// 8x8 unsigned approximate multiplier
// x selects the rows, y is the multiplicand
module lenet_approx_mul (
    input  logic [lenet_pkg::act_w-1:0]  x,
    input  logic [lenet_pkg::act_w-1:0]  y,
    output logic [lenet_pkg::prod_w-1:0] z
);

    logic [lenet_pkg::act_w-1:0] pp [lenet_pkg::act_w];  // masked copies of y

    // sparse correction words for the pruned low rows
    logic [12:0] corr1;
    logic [12:0] corr2;
    logic [12:0] corr3;
    logic [12:0] corr4;

    always_comb begin
        for (int i = 0; i < lenet_pkg::act_w; i++) begin
            pp[i] = y & {lenet_pkg::act_w{x[i]}};
        end
    end

    always_comb begin
        corr1 = '0;
        corr2 = '0;
        corr3 = '0;
        corr4 = '0;

        corr1[4]  = pp[0][3] ^ pp[1][2];
        corr1[7]  = pp[0][6] ^ pp[1][5];
        corr1[8]  = pp[0][7] | pp[1][6];
        corr1[9]  = pp[2][7] | pp[3][6];
        corr1[10] = pp[3][7];
        corr1[11] = pp[4][7] ^ pp[5][6];  // half adder sum
        corr1[12] = pp[4][7] & pp[5][6];  // and its carry

        corr2[7]  = pp[0][7] & pp[1][6];
        corr2[8]  = pp[2][5] & pp[3][4];
        corr2[9]  = pp[4][4] | pp[5][3];
        corr2[10] = pp[4][5] & pp[5][4];
        corr2[12] = pp[5][7];

        corr3[8]  = pp[2][6] | pp[3][5];
        corr3[9]  = pp[4][5] ^ pp[5][4];
        corr3[10] = pp[4][6] & pp[5][5];

        corr4[8]  = pp[4][3] | pp[5][2];
        corr4[10] = pp[4][6] | pp[5][5];
    end

    // top two rows pass through exactly
    assign z = lenet_pkg::prod_w'({pp[6], 6'b0})
             + lenet_pkg::prod_w'({pp[7], 7'b0})
             + lenet_pkg::prod_w'(corr1)
             + lenet_pkg::prod_w'(corr2)
             + lenet_pkg::prod_w'(corr3)
             + lenet_pkg::prod_w'(corr4);

endmodule

`default_nettype wire

// ==== lenet_cfg_if.sv ====
`default_nettype none

// kernel configuration as seen by the MAC pipeline
interface lenet_cfg_if;

    logic        [lenet_pkg::act_w-1:0]   weight_tap;  // weight of the requested tap
    logic        [lenet_pkg::tap_w-1:0]   tap;
    logic signed [lenet_pkg::bias_w-1:0]  bias;
    logic        [lenet_pkg::shift_w-1:0] shift;
    logic                                 busy;        // window in progress

    modport regs (
        output weight_tap, bias, shift,
        input  tap, busy
    );

    modport mac (
        input  weight_tap, bias, shift,
        output tap, busy
    );

endinterface

`default_nettype wire

// ==== lenet_pkg.sv ====
`default_nettype none

package lenet_pkg;

    // datapath widths
    localparam int act_w   = 8;   // activation and weight
    localparam int prod_w  = 16;  // multiplier output
    localparam int acc_w   = 21;  // signed accumulator, nine products plus bias
    localparam int bias_w  = 16;  // two's complement bias
    localparam int shift_w = 4;   // output right shift
    localparam int cfg_w   = 16;  // configuration data word

    // 3x3 kernel
    localparam int n_taps = 9;
    localparam int tap_w  = 4;

    // configuration write opcodes
    typedef enum logic [1:0] {
        cfg_weight = 2'd0,  // weight at cfg_addr
        cfg_bias   = 2'd1,
        cfg_shift  = 2'd2,
        cfg_nop    = 2'd3
    } cfg_op_e;

    // result register occupancy
    typedef enum logic {
        out_empty = 1'b0,
        out_full  = 1'b1
    } out_state_e;

endpackage

`default_nettype wire
